// ==== build.f ====
trap_pkg.sv
csr_file.sv
machine_timer.sv
trap_ctrl.sv
trap_unit_top.sv
trap_unit_checker.sv
tb_trap_unit.sv

// ==== csr_file.sv ====
`default_nettype none

module csr_file (
  input  wire logic                        clk_i,
  input  wire logic                        rst_i,
  input  wire trap_pkg::csr_req_t          csr_req_i,
  input  wire logic [trap_pkg::XLEN-1:0]   pc_i,
  input  wire logic                        capture_i,
  input  wire trap_pkg::mcause_t           cause_i,
  input  wire logic                        mip_timer_i,
  input  wire logic [trap_pkg::XLEN-1:0]   time_i,
  output logic      [trap_pkg::XLEN-1:0]   rdata_o,
  output logic                             mie_timer_o,
  output logic      [trap_pkg::XLEN-1:0]   mtvec_o,
  output logic      [trap_pkg::XLEN-1:0]   mepc_o
);

  logic [trap_pkg::XLEN-1:0] mie_q;
  logic [trap_pkg::XLEN-1:0] mtvec_q;
  logic [trap_pkg::XLEN-1:0] mscratch_q;
  logic [trap_pkg::XLEN-1:0] mepc_q;
  trap_pkg::mcause_t         mcause_q;

  logic [trap_pkg::XLEN-1:0] mip_val;
  logic [trap_pkg::XLEN-1:0] wr_data;
  logic                      wr_en;

  // Only the timer pending bit exists in mip
  always_comb begin
    mip_val = '0;
    mip_val[trap_pkg::IRQ_TIMER_CODE] = mip_timer_i;
  end

  always_comb begin
    case (csr_req_i.addr)
      trap_pkg::CSR_MIE:      rdata_o = mie_q;
      trap_pkg::CSR_MTVEC:    rdata_o = mtvec_q;
      trap_pkg::CSR_MSCRATCH: rdata_o = mscratch_q;
      trap_pkg::CSR_MEPC:     rdata_o = mepc_q;
      trap_pkg::CSR_MCAUSE:   rdata_o = mcause_q.raw;
      trap_pkg::CSR_MIP:      rdata_o = mip_val;
      trap_pkg::CSR_TIME:     rdata_o = time_i;
      default:                rdata_o = '0;
    endcase
  end

  assign wr_en = (csr_req_i.op != trap_pkg::CSR_NONE);

  // Clear and set work on the current value of the addressed register
  always_comb begin
    case (csr_req_i.op)
      trap_pkg::CSR_WRITE: wr_data = csr_req_i.wdata;
      trap_pkg::CSR_CLEAR: wr_data = rdata_o & ~csr_req_i.wdata;
      trap_pkg::CSR_SET:   wr_data = rdata_o | csr_req_i.wdata;
      default:             wr_data = rdata_o;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      if (wr_en) begin
        case (csr_req_i.addr)
          trap_pkg::CSR_MIE:      mie_q        <= wr_data;
          trap_pkg::CSR_MTVEC:    mtvec_q      <= wr_data;
          trap_pkg::CSR_MSCRATCH: mscratch_q   <= wr_data;
          trap_pkg::CSR_MEPC:     mepc_q       <= wr_data;
          trap_pkg::CSR_MCAUSE:   mcause_q.raw <= wr_data;
          default: ;  // mip, time and unknown addresses
        endcase
      end
      // A trap overrides a software write on the same edge
      if (capture_i) begin
        mepc_q       <= pc_i;
        mcause_q.raw <= cause_i.raw;
      end
    end
  end

  assign mie_timer_o = mie_q[trap_pkg::IRQ_TIMER_CODE];
  assign mtvec_o     = mtvec_q;
  assign mepc_o      = mepc_q;

endmodule

`default_nettype wire

// ==== machine_timer.sv ====
`default_nettype none

module machine_timer #(
  parameter int TIMER_PERIOD = 64
) (
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  output logic      [31:0] time_o,
  output logic             tick_o
);

  localparam logic [31:0] LAST_COUNT = 32'(TIMER_PERIOD - 1);

  logic [31:0] count_q;

  // Tick marks the final count of each period
  assign tick_o = (count_q == LAST_COUNT);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (tick_o) begin
      count_q <= '0;  // Wrap after the last count
    end else begin
      count_q <= count_q + 32'd1;
    end
  end

  assign time_o = count_q;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the trap unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -f build.f --top-module tb_trap_unit -o sim_trap_unit; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_trap_unit > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error status"
  exit 1
fi
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  echo "Testbench reported a failure"
  exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
  echo "Pass message missing from the log"
  exit 1
fi
exit 0

// ==== tb_trap_unit.sv ====
`default_nettype none

module tb_trap_unit;

  localparam int          CLK_PERIOD   = 100;
  localparam int          TIMER_PERIOD = 64;
  localparam int          WAIT_LIMIT   = 20;
  localparam logic [31:0] MTIE_MASK    = 32'h0000_0080;

  logic                clk;
  logic                rst;
  trap_pkg::csr_req_t  csr_req;
  logic [31:0]         pc;
  logic                exc;
  trap_pkg::exc_code_t exc_code;
  logic                mret;
  logic [31:0]         rdata;
  logic                trap;
  logic [31:0]         trap_pc;
  logic                ret;
  logic [31:0]         ret_pc;
  logic [31:0]         lfsr_state;

  trap_unit_top #(
    .TIMER_PERIOD (TIMER_PERIOD)
  ) trap_unit_top_inst (
    .clk_i      (clk),
    .rst_i      (rst),
    .csr_req_i  (csr_req),
    .pc_i       (pc),
    .exc_i      (exc),
    .exc_code_i (exc_code),
    .mret_i     (mret),
    .rdata_o    (rdata),
    .trap_o     (trap),
    .trap_pc_o  (trap_pc),
    .ret_o      (ret),
    .ret_pc_o   (ret_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, actual, expected);
      $display("sim failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("sim failed");
    $fatal(1, "timeout");
  endtask

  // Taps 32, 22, 2 and 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) w = {w[30:0], lfsr_step()};
    return w;
  endfunction

  task automatic csr_access(input trap_pkg::csr_op_e op, input logic [11:0] addr,
                            input logic [31:0] data);
    @(negedge clk);
    csr_req.op    = op;
    csr_req.addr  = addr;
    csr_req.wdata = data;
    @(negedge clk);
    csr_req.op = trap_pkg::CSR_NONE;
  endtask

  task automatic read_csr(input logic [11:0] addr, output logic [31:0] value);
    @(negedge clk);
    csr_req.op   = trap_pkg::CSR_NONE;
    csr_req.addr = addr;
    #(CLK_PERIOD / 4);  // rdata_o is combinational from the address
    value = rdata;
  endtask

  task automatic expect_csr(input logic [11:0] addr, input logic [31:0] expected);
    logic [31:0] value;
    read_csr(addr, value);
    check_value($sformatf("rdata_o[%h]", addr), value, expected);
  endtask

  // Called right after a falling edge
  task automatic expect_quiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      check_value("trap_o", 32'(trap), 0);
      check_value("ret_o", 32'(ret), 0);
      @(negedge clk);
    end
  endtask

  task automatic wait_for_trap(input int limit);
    int count;
    count = 0;
    while (!trap && count < limit) begin
      @(negedge clk);
      count++;
    end
    if (!trap) report_timeout("no trap_o pulse arrived");
  endtask

  task automatic reset_values_test();
    expect_csr(trap_pkg::CSR_MIE, 0);
    expect_csr(trap_pkg::CSR_MTVEC, 0);
    expect_csr(trap_pkg::CSR_MSCRATCH, 0);
    expect_csr(trap_pkg::CSR_MEPC, 0);
    expect_csr(trap_pkg::CSR_MCAUSE, 0);
    check_value("trap_o", 32'(trap), 0);
    check_value("ret_o", 32'(ret), 0);
  endtask

  task automatic csr_ops_test();
    logic [11:0] addr_list [5];
    logic [31:0] model [5];
    logic [31:0] mask;
    logic [31:0] value;
    int          i;
    addr_list = '{trap_pkg::CSR_MIE, trap_pkg::CSR_MTVEC, trap_pkg::CSR_MSCRATCH,
                  trap_pkg::CSR_MEPC, trap_pkg::CSR_MCAUSE};
    for (i = 0; i < 5; i++) begin
      mask = rand_word();
      if (i == 0) mask = mask & ~MTIE_MASK;  // Timer interrupt stays off here
      csr_access(trap_pkg::CSR_WRITE, addr_list[i], mask);
      model[i] = mask;
      expect_csr(addr_list[i], model[i]);
    end
    for (i = 0; i < 5; i++) begin
      mask = rand_word();
      csr_access(trap_pkg::CSR_CLEAR, addr_list[i], mask);
      model[i] = model[i] & ~mask;
      expect_csr(addr_list[i], model[i]);
      mask = rand_word();
      if (i == 0) mask = mask & ~MTIE_MASK;
      csr_access(trap_pkg::CSR_SET, addr_list[i], mask);
      model[i] = model[i] | mask;
      expect_csr(addr_list[i], model[i]);
    end
    csr_access(trap_pkg::CSR_WRITE, trap_pkg::CSR_MIP, '1);
    read_csr(trap_pkg::CSR_MIP, value);
    check_value("mip non-timer bits", value & ~MTIE_MASK, 0);
    csr_access(trap_pkg::CSR_WRITE, trap_pkg::CSR_TIME, '1);
    read_csr(trap_pkg::CSR_TIME, value);
    check_value("time below period", 32'(value < TIMER_PERIOD), 1);
  endtask

  task automatic exception_trap_test();
    logic [31:0] vec;
    vec = rand_word() & 32'hFFFF_FFFC;
    csr_access(trap_pkg::CSR_WRITE, trap_pkg::CSR_MTVEC, vec);
    @(negedge clk);
    pc       = 32'h0000_1a40;
    exc_code = 31'd2;
    exc      = 1'b1;
    @(negedge clk);
    exc = 1'b0;
    check_value("trap_o", 32'(trap), 1);
    check_value("trap_pc_o", trap_pc, vec);
    @(negedge clk);
    check_value("trap_o", 32'(trap), 0);
    expect_csr(trap_pkg::CSR_MEPC, 32'h0000_1a40);
    expect_csr(trap_pkg::CSR_MCAUSE, {1'b0, 31'd2});
    // A second exception inside the handler is dropped
    @(negedge clk);
    pc       = 32'h0000_2000;
    exc_code = 31'd11;
    exc      = 1'b1;
    @(negedge clk);
    exc = 1'b0;
    expect_quiet(WAIT_LIMIT);
    expect_csr(trap_pkg::CSR_MEPC, 32'h0000_1a40);
    expect_csr(trap_pkg::CSR_MCAUSE, {1'b0, 31'd2});
  endtask

  task automatic return_test();
    logic [31:0] epc;
    epc = rand_word() & 32'hFFFF_FFFC;
    csr_access(trap_pkg::CSR_WRITE, trap_pkg::CSR_MEPC, epc);
    @(negedge clk);
    mret = 1'b1;
    @(negedge clk);
    mret = 1'b0;
    check_value("ret_o", 32'(ret), 1);
    check_value("ret_pc_o", ret_pc, epc);
    @(negedge clk);
    mret = 1'b1;  // Back in RUN, so this one is ignored
    @(negedge clk);
    mret = 1'b0;
    expect_quiet(WAIT_LIMIT);
  endtask

  task automatic timer_irq_test();
    logic [31:0] value;
    logic [31:0] next_time;
    pc = 32'h0000_3c00;
    csr_access(trap_pkg::CSR_WRITE, trap_pkg::CSR_MIE, 0);
    expect_quiet(TIMER_PERIOD + 8);
    read_csr(trap_pkg::CSR_MIP, value);
    check_value("mip.mtip", 32'(value[7]), 1);
    csr_access(trap_pkg::CSR_SET, trap_pkg::CSR_MIE, MTIE_MASK);
    wait_for_trap(WAIT_LIMIT);
    expect_csr(trap_pkg::CSR_MCAUSE, {1'b1, 31'd7});
    expect_csr(trap_pkg::CSR_MEPC, 32'h0000_3c00);
    read_csr(trap_pkg::CSR_TIME, value);
    check_value("time below period", 32'(value < TIMER_PERIOD), 1);
    // Reads one clock apart see the counter advance by one
    read_csr(trap_pkg::CSR_TIME, next_time);
    check_value("time step", next_time, (value + 32'd1) % TIMER_PERIOD);
  endtask

  task automatic priority_test();
    int count;
    count = 0;
    @(negedge clk);
    csr_req.addr = trap_pkg::CSR_MIP;
    #(CLK_PERIOD / 4);
    while (!rdata[7] && count < 2 * TIMER_PERIOD) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      count++;
    end
    if (!rdata[7]) report_timeout("timer interrupt never pending in the handler");
    @(negedge clk);
    mret = 1'b1;
    @(negedge clk);
    mret     = 1'b0;
    pc       = 32'h0000_4400;
    exc_code = 31'd3;
    exc      = 1'b1;  // Meets the pending interrupt on the first RUN edge
    check_value("ret_o", 32'(ret), 1);
    @(negedge clk);
    exc = 1'b0;
    check_value("trap_o", 32'(trap), 1);
    expect_csr(trap_pkg::CSR_MCAUSE, {1'b0, 31'd3});
    @(negedge clk);
    mret = 1'b1;
    pc   = 32'h0000_5000;
    @(negedge clk);
    mret = 1'b0;
    check_value("ret_o", 32'(ret), 1);
    check_value("trap_o", 32'(trap), 0);
    @(negedge clk);
    check_value("trap_o", 32'(trap), 1);
    expect_csr(trap_pkg::CSR_MCAUSE, {1'b1, 31'd7});
    expect_csr(trap_pkg::CSR_MEPC, 32'h0000_5000);
  endtask

  initial begin
    lfsr_state = 32'h3a5e;
    rst        = 1'b1;
    csr_req    = '0;
    pc         = '0;
    exc        = 1'b0;
    exc_code   = '0;
    mret       = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    reset_values_test();
    csr_ops_test();
    exception_trap_test();
    return_test();
    timer_irq_test();
    priority_test();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== trap_ctrl.sv ====
`default_nettype none

module trap_ctrl (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  exc_i,
  input  wire trap_pkg::exc_code_t   exc_code_i,
  input  wire logic                  mret_i,
  input  wire logic                  tick_i,
  input  wire logic                  mie_timer_i,
  output logic                       capture_o,
  output trap_pkg::mcause_t          cause_o,
  output logic                       mip_timer_o,
  output logic                       trap_o,
  output logic                       ret_o
);

  typedef enum logic {
    RUN     = 1'b0,
    HANDLER = 1'b1
  } state_e;

  state_e state_q;
  logic   pending_q;
  logic   take_exc;
  logic   take_irq;
  logic   do_ret;

  // Exceptions win over the timer interrupt
  assign take_exc = (state_q == RUN) && exc_i;
  assign take_irq = (state_q == RUN) && pending_q && mie_timer_i && !exc_i;
  assign do_ret   = (state_q == HANDLER) && mret_i;

  assign capture_o = take_exc | take_irq;

  always_comb begin
    cause_o.fields.interrupt = !take_exc;
    cause_o.fields.code      = take_exc ? exc_code_i : 31'(trap_pkg::IRQ_TIMER_CODE);
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= RUN;
    end else if (capture_o) begin
      state_q <= HANDLER;
    end else if (do_ret) begin
      state_q <= RUN;
    end
  end

  // A fresh tick keeps the flag set even when the old one is taken
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pending_q <= 1'b0;
    end else if (tick_i) begin
      pending_q <= 1'b1;
    end else if (take_irq) begin
      pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      trap_o <= 1'b0;
      ret_o  <= 1'b0;
    end else begin
      trap_o <= capture_o;
      ret_o  <= do_ret;
    end
  end

  assign mip_timer_o = pending_q;

endmodule

`default_nettype wire

// ==== trap_pkg.sv ====
`default_nettype none

package trap_pkg;

  localparam int XLEN = 32;

  // Machine-mode CSR addresses
  localparam logic [11:0] CSR_MIE      = 12'h304;
  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;

  // Read-only views that drop any write
  localparam logic [11:0] CSR_MIP  = 12'h344;
  localparam logic [11:0] CSR_TIME = 12'hC01;

  // Timer interrupt code and the MTIE/MTIP bit index
  localparam int unsigned IRQ_TIMER_CODE = 7;

  typedef enum logic [1:0] {
    CSR_NONE  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_CLEAR = 2'd2,
    CSR_SET   = 2'd3
  } csr_op_e;

  typedef struct packed {
    csr_op_e          op;
    logic [11:0]      addr;
    logic [XLEN-1:0]  wdata;
  } csr_req_t;

  typedef logic [XLEN-2:0] exc_code_t;

  typedef struct packed {
    logic       interrupt;  // Set for asynchronous causes
    exc_code_t  code;
  } mcause_fields_t;

  // mcause is stored as a plain word but built from its fields
  typedef union packed {
    logic [XLEN-1:0] raw;
    mcause_fields_t  fields;
  } mcause_t;

endpackage

`default_nettype wire

// ==== trap_unit_checker.sv ====
`default_nettype none

module trap_unit_checker (
  input wire logic        clk_i,
  input wire logic        rst_i,
  input wire logic        trap_i,
  input wire logic        ret_i,
  input wire logic [31:0] trap_pc_i
);

  a_trap_single: assert property (@(posedge clk_i) disable iff (rst_i) trap_i |=> !trap_i)
    else $error("trap_o stayed high for two cycles");

  a_trap_ret_exclusive: assert property (@(posedge clk_i) disable iff (rst_i) !(trap_i && ret_i))
    else $error("trap_o and ret_o high together");

  // The redirect target must not move under a trap pulse
  a_trap_pc_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    trap_i |-> $stable(trap_pc_i))
    else $error("trap_pc_o changed while trap_o was high");

  a_reset_quiet: assert property (@(posedge clk_i) rst_i |-> (!trap_i && !ret_i))
    else $error("trap_o or ret_o high during reset");

endmodule

bind trap_unit_top trap_unit_checker trap_unit_checker_inst (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .trap_i    (trap_o),
  .ret_i     (ret_o),
  .trap_pc_i (trap_pc_o)
);

`default_nettype wire

// ==== trap_unit_top.sv ====
`default_nettype none

module trap_unit_top #(
  parameter int TIMER_PERIOD = 64
) (
  input  wire logic                        clk_i,
  input  wire logic                        rst_i,
  input  wire trap_pkg::csr_req_t          csr_req_i,
  input  wire logic [trap_pkg::XLEN-1:0]   pc_i,
  input  wire logic                        exc_i,
  input  wire trap_pkg::exc_code_t         exc_code_i,
  input  wire logic                        mret_i,
  output logic      [trap_pkg::XLEN-1:0]   rdata_o,
  output logic                             trap_o,
  output logic      [trap_pkg::XLEN-1:0]   trap_pc_o,
  output logic                             ret_o,
  output logic      [trap_pkg::XLEN-1:0]   ret_pc_o
);

  logic [31:0]       time_val;
  logic              tick;
  logic              capture;
  trap_pkg::mcause_t cause;
  logic              mip_timer;
  logic              mie_timer;

  trap_ctrl trap_ctrl_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .exc_i       (exc_i),
    .exc_code_i  (exc_code_i),
    .mret_i      (mret_i),
    .tick_i      (tick),
    .mie_timer_i (mie_timer),
    .capture_o   (capture),
    .cause_o     (cause),
    .mip_timer_o (mip_timer),
    .trap_o      (trap_o),
    .ret_o       (ret_o)
  );

  machine_timer #(
    .TIMER_PERIOD (TIMER_PERIOD)
  ) machine_timer_inst (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .time_o (time_val),
    .tick_o (tick)
  );

  // Redirect and return targets come straight from mtvec and mepc
  csr_file csr_file_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .csr_req_i   (csr_req_i),
    .pc_i        (pc_i),
    .capture_i   (capture),
    .cause_i     (cause),
    .mip_timer_i (mip_timer),
    .time_i      (time_val),
    .rdata_o     (rdata_o),
    .mie_timer_o (mie_timer),
    .mtvec_o     (trap_pc_o),
    .mepc_o      (ret_pc_o)
  );

endmodule

`default_nettype wire
